//--- include/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

////////////////////
// datapath widths
////////////////////

// instruction and data words share one width
`define XLEN 32

// register file addressing
`define REG_ADDR_W 5
`define NUM_REGS 32

////////////////////
// memory addressing
////////////////////

// word addresses into the external memories
`define IMEM_ADDR_W 6
`define DMEM_ADDR_W 6

// low bits of a byte address that select a byte inside a word
`define BYTE_OFS_W 2

`endif

//--- source/isa_pkg.sv
`include "mips_defines.svh"

package isa_pkg;

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		R_TYPE     = 6'b000000,
		LOAD_WORD  = 6'b100011,
		STORE_WORD = 6'b101011
	} opcode_e;

	// r-type function codes, instr[5:0]
	typedef enum logic [5:0] {
		FN_ADD = 6'b100000,
		FN_SUB = 6'b100010,
		FN_AND = 6'b100100,
		FN_OR  = 6'b100101,
		FN_NOR = 6'b100111,
		FN_SLT = 6'b101010
	} funct_e;

	// register form
	typedef struct packed {
		opcode_e                opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] rd;
		logic [4:0]             shamt;
		funct_e                 funct;
	} r_fields_t;

	// immediate form, used by lw and sw
	typedef struct packed {
		opcode_e                opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [15:0]            imm16;
	} i_fields_t;

	// same word seen as either form
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

endpackage

//--- source/pipe_pkg.sv
package pipe_pkg;

	// coarse alu request coming out of main decode
	typedef enum logic [1:0] {
		ALU_OP_ADD   = 2'b00,
		ALU_OP_RSVD  = 2'b01,
		ALU_OP_FUNCT = 2'b10
	} alu_op_e;

	// operation select seen by the alu itself
	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_OR  = 4'b0001,
		ALU_ADD = 4'b0010,
		ALU_SUB = 4'b0110,
		ALU_SLT = 4'b0111,
		ALU_NOR = 4'b1100
	} alu_ctrl_e;

	// source of one ex operand
	typedef enum logic [1:0] {
		FWD_RF  = 2'b00,
		FWD_MEM = 2'b01,
		FWD_WB  = 2'b10
	} fwd_sel_e;

	// control bundle carried from id into ex
	typedef struct packed {
		logic    reg_dst;
		logic    alu_src;
		logic    mem_to_reg;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		alu_op_e alu_op;
	} ctrl_t;

endpackage

//--- source/register_file.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module register_file (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`REG_ADDR_W-1:0] ra1,
	input  logic [`REG_ADDR_W-1:0] ra2,
	input  logic                   we,
	input  logic [`REG_ADDR_W-1:0] wa,
	input  logic [`XLEN-1:0]       wd,
	output logic [`XLEN-1:0]       rd1,
	output logic [`XLEN-1:0]       rd2
);

	logic [`XLEN-1:0] regs [`NUM_REGS];
	logic             wr_live;

	// r0 is never written so it keeps its reset value
	assign wr_live = we && (wa != '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			regs <= '{default: '0};
		end else if (wr_live) begin
			regs[wa] <= wd;
		end
	end

	// same-cycle write shows up on the read port
	assign rd1 = (wr_live && (wa == ra1)) ? wd : regs[ra1];
	assign rd2 = (wr_live && (wa == ra2)) ? wd : regs[ra2];

endmodule

//--- source/fetch_stage.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module fetch_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    stall,
	input  logic [`XLEN-1:0]        imem_data,
	output logic [`IMEM_ADDR_W-1:0] imem_addr,
	output isa_pkg::instr_u         if_id_instr
);

	// byte address of the instruction being fetched
	logic [`XLEN-1:0] pc;

	// word address for instruction memory
	assign imem_addr = pc[`BYTE_OFS_W +: `IMEM_ADDR_W];

	// pc moves on one word per cycle and holds under a load-use stall
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pc + (`XLEN'(1) << `BYTE_OFS_W);
		end
	end

	////////////////////
	// if/id register
	////////////////////

	// an all-zero word is a no-op that writes r0
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			if_id_instr <= '0;
		end else if (!stall) begin
			if_id_instr <= imem_data;
		end
	end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module decode_stage (
	input  logic                   clk,
	input  logic                   rst,
	input  isa_pkg::instr_u        if_id_instr,
	// instruction currently in ex
	input  logic                   ex_mem_read,
	input  logic [`REG_ADDR_W-1:0] ex_rt,
	// writeback port of the register file
	input  logic                   wb_reg_write,
	input  logic [`REG_ADDR_W-1:0] wb_dest,
	input  logic [`XLEN-1:0]       wb_data,
	output logic                   stall,
	// id/ex contents
	output pipe_pkg::ctrl_t        id_ex_ctrl,
	output logic [`REG_ADDR_W-1:0] id_ex_rs,
	output logic [`REG_ADDR_W-1:0] id_ex_rt,
	output logic [`REG_ADDR_W-1:0] id_ex_rd,
	output logic [`XLEN-1:0]       id_ex_rd1,
	output logic [`XLEN-1:0]       id_ex_rd2,
	output logic [`XLEN-1:0]       id_ex_imm
);

	import isa_pkg::*;
	import pipe_pkg::*;

	ctrl_t                  ctrl;
	logic [`REG_ADDR_W-1:0] rs;
	logic [`REG_ADDR_W-1:0] rt;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`XLEN-1:0]       rf_rd1;
	logic [`XLEN-1:0]       rf_rd2;
	logic [`XLEN-1:0]       imm_ext;

	// rs and rt sit at the same place in both forms
	assign rs = if_id_instr.r.rs;
	assign rt = if_id_instr.r.rt;
	// rd only means something for r-type
	assign rd = if_id_instr.r.rd;

	////////////////////
	// main control
	////////////////////

	always_comb begin
		// anything not decoded below stays a bubble
		ctrl = '0;
		case (if_id_instr.r.opcode)
			R_TYPE: begin
				ctrl.reg_dst   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = ALU_OP_FUNCT;
			end
			LOAD_WORD: begin
				// base plus offset, loaded word goes to rt
				ctrl.alu_src    = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.alu_op     = ALU_OP_ADD;
			end
			STORE_WORD: begin
				// rt only supplies store data
				ctrl.alu_src   = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.alu_op    = ALU_OP_ADD;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

	// load in ex whose target is read here
	assign stall = ex_mem_read && ((ex_rt == rs) || (ex_rt == rt));

	// offset field of the i-form, sign extended
	assign imm_ext = {{(`XLEN-16){if_id_instr.i.imm16[15]}}, if_id_instr.i.imm16};

	register_file i_register_file (
		.clk (clk),
		.rst (rst),
		.ra1 (rs),
		.ra2 (rt),
		.we  (wb_reg_write),
		.wa  (wb_dest),
		.wd  (wb_data),
		.rd1 (rf_rd1),
		.rd2 (rf_rd2)
	);

	////////////////////
	// id/ex register
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			id_ex_ctrl <= '0;
			id_ex_rs   <= '0;
			id_ex_rt   <= '0;
			id_ex_rd   <= '0;
			id_ex_rd1  <= '0;
			id_ex_rd2  <= '0;
			id_ex_imm  <= '0;
		end else begin
			// zero control is enough for a bubble
			if (stall) begin
				id_ex_ctrl <= '0;
			end else begin
				id_ex_ctrl <= ctrl;
			end
			id_ex_rs  <= rs;
			id_ex_rt  <= rt;
			id_ex_rd  <= rd;
			id_ex_rd1 <= rf_rd1;
			id_ex_rd2 <= rf_rd2;
			// low six bits double as funct for r-type
			id_ex_imm <= imm_ext;
		end
	end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module execute_stage (
	input  logic                   clk,
	input  logic                   rst,
	// id/ex contents
	input  pipe_pkg::ctrl_t        id_ex_ctrl,
	input  logic [`REG_ADDR_W-1:0] id_ex_rs,
	input  logic [`REG_ADDR_W-1:0] id_ex_rt,
	input  logic [`REG_ADDR_W-1:0] id_ex_rd,
	input  logic [`XLEN-1:0]       id_ex_rd1,
	input  logic [`XLEN-1:0]       id_ex_rd2,
	input  logic [`XLEN-1:0]       id_ex_imm,
	// mem stage result
	input  logic                   mem_reg_write,
	input  logic [`REG_ADDR_W-1:0] mem_dest,
	input  logic [`XLEN-1:0]       mem_alu_result,
	// wb stage result
	input  logic                   wb_reg_write,
	input  logic [`REG_ADDR_W-1:0] wb_dest,
	input  logic [`XLEN-1:0]       wb_data,
	// seen by the hazard check in id
	output logic                   ex_mem_read,
	output logic [`REG_ADDR_W-1:0] ex_rt,
	// ex/mem contents
	output logic                   ex_mem_mem_to_reg,
	output logic                   ex_mem_reg_write,
	output logic                   ex_mem_mem_read,
	output logic                   ex_mem_mem_write,
	output logic [`REG_ADDR_W-1:0] ex_mem_dest,
	output logic [`XLEN-1:0]       ex_mem_alu_result,
	output logic [`XLEN-1:0]       ex_mem_store_data
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// code outside the six alu operations, the alu answers zero
	localparam alu_ctrl_e ALU_CTRL_ZERO = alu_ctrl_e'(4'b1111);

	fwd_sel_e               fwd_a;
	fwd_sel_e               fwd_b;
	logic [`XLEN-1:0]       op_a;
	logic [`XLEN-1:0]       fwd_b_val;
	logic [`XLEN-1:0]       op_b;
	funct_e                 funct;
	alu_ctrl_e              alu_ctrl;
	logic [`XLEN-1:0]       alu_result;
	logic [`REG_ADDR_W-1:0] dest;

	// older stage writes a register this operand reads
	function automatic logic fwd_hit(
		input logic                   we,
		input logic [`REG_ADDR_W-1:0] dst,
		input logic [`REG_ADDR_W-1:0] src
	);
		return we && (dst != '0) && (dst == src);
	endfunction

	function automatic logic [`XLEN-1:0] fwd_mux(
		input fwd_sel_e         sel,
		input logic [`XLEN-1:0] rf_val,
		input logic [`XLEN-1:0] mem_val,
		input logic [`XLEN-1:0] wb_val
	);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return rf_val;
		endcase
	endfunction

	assign ex_mem_read = id_ex_ctrl.mem_read;
	assign ex_rt       = id_ex_rt;

	////////////////////
	// forwarding
	////////////////////

	// mem is younger than wb so it is checked first
	assign fwd_a = fwd_hit(mem_reg_write, mem_dest, id_ex_rs) ? FWD_MEM :
		fwd_hit(wb_reg_write, wb_dest, id_ex_rs) ? FWD_WB : FWD_RF;
	assign fwd_b = fwd_hit(mem_reg_write, mem_dest, id_ex_rt) ? FWD_MEM :
		fwd_hit(wb_reg_write, wb_dest, id_ex_rt) ? FWD_WB : FWD_RF;

	assign op_a      = fwd_mux(fwd_a, id_ex_rd1, mem_alu_result, wb_data);
	assign fwd_b_val = fwd_mux(fwd_b, id_ex_rd2, mem_alu_result, wb_data);
	// lw and sw add the offset instead of rt
	assign op_b      = id_ex_ctrl.alu_src ? id_ex_imm : fwd_b_val;

	////////////////////
	// alu control and alu
	////////////////////

	assign funct = funct_e'(id_ex_imm[5:0]);

	always_comb begin
		alu_ctrl = ALU_CTRL_ZERO;
		case (id_ex_ctrl.alu_op)
			ALU_OP_ADD: alu_ctrl = ALU_ADD;
			ALU_OP_FUNCT: begin
				case (funct)
					FN_ADD:  alu_ctrl = ALU_ADD;
					FN_SUB:  alu_ctrl = ALU_SUB;
					FN_AND:  alu_ctrl = ALU_AND;
					FN_OR:   alu_ctrl = ALU_OR;
					FN_SLT:  alu_ctrl = ALU_SLT;
					FN_NOR:  alu_ctrl = ALU_NOR;
					default: alu_ctrl = ALU_CTRL_ZERO;
				endcase
			end
			// reserved code has no operation behind it
			default: alu_ctrl = ALU_CTRL_ZERO;
		endcase
	end

	always_comb begin
		case (alu_ctrl)
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			ALU_ADD: alu_result = op_a + op_b;
			ALU_SUB: alu_result = op_a - op_b;
			// two's complement compare
			ALU_SLT: alu_result = `XLEN'($signed(op_a) < $signed(op_b));
			ALU_NOR: alu_result = ~(op_a | op_b);
			default: alu_result = '0;
		endcase
	end

	// r-type writes rd, lw writes rt
	assign dest = id_ex_ctrl.reg_dst ? id_ex_rd : id_ex_rt;

	////////////////////
	// ex/mem register
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_mem_mem_to_reg <= 1'b0;
			ex_mem_reg_write  <= 1'b0;
			ex_mem_mem_read   <= 1'b0;
			ex_mem_mem_write  <= 1'b0;
			ex_mem_dest       <= '0;
			ex_mem_alu_result <= '0;
			ex_mem_store_data <= '0;
		end else begin
			ex_mem_mem_to_reg <= id_ex_ctrl.mem_to_reg;
			ex_mem_reg_write  <= id_ex_ctrl.reg_write;
			ex_mem_mem_read   <= id_ex_ctrl.mem_read;
			ex_mem_mem_write  <= id_ex_ctrl.mem_write;
			ex_mem_dest       <= dest;
			ex_mem_alu_result <= alu_result;
			// sw data must carry the forwarded rt
			ex_mem_store_data <= fwd_b_val;
		end
	end

endmodule

//--- source/memory_writeback.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module memory_writeback (
	input  logic                    clk,
	input  logic                    rst,
	// ex/mem contents
	input  logic                    ex_mem_mem_to_reg,
	input  logic                    ex_mem_reg_write,
	input  logic                    ex_mem_mem_read,
	input  logic                    ex_mem_mem_write,
	input  logic [`REG_ADDR_W-1:0]  ex_mem_dest,
	input  logic [`XLEN-1:0]        ex_mem_alu_result,
	input  logic [`XLEN-1:0]        ex_mem_store_data,
	input  logic [`XLEN-1:0]        dmem_rdata,
	// data memory port
	output logic [`DMEM_ADDR_W-1:0] dmem_addr,
	output logic [`XLEN-1:0]        dmem_wdata,
	output logic                    dmem_we,
	output logic                    dmem_re,
	// mem stage forwarding source
	output logic                    mem_reg_write,
	output logic [`REG_ADDR_W-1:0]  mem_dest,
	output logic [`XLEN-1:0]        mem_alu_result,
	// writeback
	output logic                    wb_reg_write,
	output logic [`REG_ADDR_W-1:0]  wb_dest,
	output logic [`XLEN-1:0]        wb_data
);

	logic             wb_mem_to_reg;
	logic [`XLEN-1:0] wb_load_data;
	logic [`XLEN-1:0] wb_alu_result;

	// byte offset is dropped from the alu address
	assign dmem_addr  = ex_mem_alu_result[`BYTE_OFS_W +: `DMEM_ADDR_W];
	assign dmem_wdata = ex_mem_store_data;
	assign dmem_we    = ex_mem_mem_write;
	assign dmem_re    = ex_mem_mem_read;

	assign mem_reg_write  = ex_mem_reg_write;
	assign mem_dest       = ex_mem_dest;
	assign mem_alu_result = ex_mem_alu_result;

	////////////////////
	// mem/wb register
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_mem_to_reg <= 1'b0;
			wb_reg_write  <= 1'b0;
			wb_dest       <= '0;
			wb_load_data  <= '0;
			wb_alu_result <= '0;
		end else begin
			wb_mem_to_reg <= ex_mem_mem_to_reg;
			wb_reg_write  <= ex_mem_reg_write;
			wb_dest       <= ex_mem_dest;
			// memory answers in the same cycle
			wb_load_data  <= dmem_rdata;
			wb_alu_result <= ex_mem_alu_result;
		end
	end

	// loaded word for lw, alu result for r-type
	assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

//--- source/mips_pipeline_top.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module mips_pipeline_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`XLEN-1:0]        imem_data,
	input  logic [`XLEN-1:0]        dmem_rdata,
	output logic [`IMEM_ADDR_W-1:0] imem_addr,
	output logic [`DMEM_ADDR_W-1:0] dmem_addr,
	output logic [`XLEN-1:0]        dmem_wdata,
	output logic                    dmem_we,
	output logic                    dmem_re
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// if/id and hazard
	instr_u                 if_id_instr;
	logic                   stall;

	// id/ex
	ctrl_t                  id_ex_ctrl;
	logic [`REG_ADDR_W-1:0] id_ex_rs;
	logic [`REG_ADDR_W-1:0] id_ex_rt;
	logic [`REG_ADDR_W-1:0] id_ex_rd;
	logic [`XLEN-1:0]       id_ex_rd1;
	logic [`XLEN-1:0]       id_ex_rd2;
	logic [`XLEN-1:0]       id_ex_imm;
	logic                   ex_mem_read;
	logic [`REG_ADDR_W-1:0] ex_rt;

	// ex/mem
	logic                   ex_mem_mem_to_reg;
	logic                   ex_mem_reg_write;
	logic                   ex_mem_mem_read;
	logic                   ex_mem_mem_write;
	logic [`REG_ADDR_W-1:0] ex_mem_dest;
	logic [`XLEN-1:0]       ex_mem_alu_result;
	logic [`XLEN-1:0]       ex_mem_store_data;

	// feedback from mem and wb
	logic                   mem_reg_write;
	logic [`REG_ADDR_W-1:0] mem_dest;
	logic [`XLEN-1:0]       mem_alu_result;
	logic                   wb_reg_write;
	logic [`REG_ADDR_W-1:0] wb_dest;
	logic [`XLEN-1:0]       wb_data;

	fetch_stage i_fetch_stage (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.imem_data   (imem_data),
		.imem_addr   (imem_addr),
		.if_id_instr (if_id_instr)
	);

	decode_stage i_decode_stage (
		.clk          (clk),
		.rst          (rst),
		.if_id_instr  (if_id_instr),
		.ex_mem_read  (ex_mem_read),
		.ex_rt        (ex_rt),
		.wb_reg_write (wb_reg_write),
		.wb_dest      (wb_dest),
		.wb_data      (wb_data),
		.stall        (stall),
		.id_ex_ctrl   (id_ex_ctrl),
		.id_ex_rs     (id_ex_rs),
		.id_ex_rt     (id_ex_rt),
		.id_ex_rd     (id_ex_rd),
		.id_ex_rd1    (id_ex_rd1),
		.id_ex_rd2    (id_ex_rd2),
		.id_ex_imm    (id_ex_imm)
	);

	execute_stage i_execute_stage (
		.clk               (clk),
		.rst               (rst),
		.id_ex_ctrl        (id_ex_ctrl),
		.id_ex_rs          (id_ex_rs),
		.id_ex_rt          (id_ex_rt),
		.id_ex_rd          (id_ex_rd),
		.id_ex_rd1         (id_ex_rd1),
		.id_ex_rd2         (id_ex_rd2),
		.id_ex_imm         (id_ex_imm),
		.mem_reg_write     (mem_reg_write),
		.mem_dest          (mem_dest),
		.mem_alu_result    (mem_alu_result),
		.wb_reg_write      (wb_reg_write),
		.wb_dest           (wb_dest),
		.wb_data           (wb_data),
		.ex_mem_read       (ex_mem_read),
		.ex_rt             (ex_rt),
		.ex_mem_mem_to_reg (ex_mem_mem_to_reg),
		.ex_mem_reg_write  (ex_mem_reg_write),
		.ex_mem_mem_read   (ex_mem_mem_read),
		.ex_mem_mem_write  (ex_mem_mem_write),
		.ex_mem_dest       (ex_mem_dest),
		.ex_mem_alu_result (ex_mem_alu_result),
		.ex_mem_store_data (ex_mem_store_data)
	);

	memory_writeback i_memory_writeback (
		.clk               (clk),
		.rst               (rst),
		.ex_mem_mem_to_reg (ex_mem_mem_to_reg),
		.ex_mem_reg_write  (ex_mem_reg_write),
		.ex_mem_mem_read   (ex_mem_mem_read),
		.ex_mem_mem_write  (ex_mem_mem_write),
		.ex_mem_dest       (ex_mem_dest),
		.ex_mem_alu_result (ex_mem_alu_result),
		.ex_mem_store_data (ex_mem_store_data),
		.dmem_rdata        (dmem_rdata),
		.dmem_addr         (dmem_addr),
		.dmem_wdata        (dmem_wdata),
		.dmem_we           (dmem_we),
		.dmem_re           (dmem_re),
		.mem_reg_write     (mem_reg_write),
		.mem_dest          (mem_dest),
		.mem_alu_result    (mem_alu_result),
		.wb_reg_write      (wb_reg_write),
		.wb_dest           (wb_dest),
		.wb_data           (wb_data)
	);

endmodule

//--- bench/store_checker.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module store_checker (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    dmem_we,
	input  logic                    dmem_re,
	input  logic [`DMEM_ADDR_W-1:0] dmem_addr,
	input  logic [`XLEN-1:0]        dmem_wdata,
	output logic                    done
);

	// expected stores in program order
	string            exp_name [$];
	int               exp_addr [$];
	logic [`XLEN-1:0] exp_data [$];

	int next_idx;
	int mismatch_count;
	int error_count;

	task automatic skip_line(input int fd);
		int c;
		c = $fgetc(fd);
		while (c != 10 && c != -1) begin
			c = $fgetc(fd);
		end
	endtask

	// only S lines matter here: test name, word address, data
	task automatic read_expected();
		int               fd;
		int               addr;
		string            tag;
		string            name;
		logic [`XLEN-1:0] data;
		fd = $fopen("bench/golden_program.txt", "r");
		if (fd == 0) begin
			$display("ERROR: store checker cannot open bench/golden_program.txt");
			error_count++;
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "S") begin
				if ($fscanf(fd, "%s %d %h", name, addr, data) == 3) begin
					exp_name.push_back(name);
					exp_addr.push_back(addr);
					exp_data.push_back(data);
				end else begin
					$display("ERROR: bad expected store line in golden file");
					error_count++;
				end
			end
			skip_line(fd);
		end
		$fclose(fd);
		if (exp_addr.size() == 0) begin
			$display("ERROR: golden file holds no expected stores");
			error_count++;
		end
	endtask

	// one store seen on the port against the next expected one
	task automatic check_store();
		if (next_idx >= exp_addr.size()) begin
			$display("ERROR: unexpected store of %h to word %0d after all expected stores",
				dmem_wdata, dmem_addr);
			error_count++;
			return;
		end
		if (dmem_addr !== `DMEM_ADDR_W'(exp_addr[next_idx])) begin
			$display("MISMATCH %s store %0d address: expected %0d actual %0d",
				exp_name[next_idx], next_idx, exp_addr[next_idx], dmem_addr);
			mismatch_count++;
		end
		if (dmem_wdata !== exp_data[next_idx]) begin
			$display("MISMATCH %s store %0d data: expected %h actual %h",
				exp_name[next_idx], next_idx, exp_data[next_idx], dmem_wdata);
			mismatch_count++;
		end
		next_idx++;
	endtask

	// end of run, anything still expected never arrived
	task automatic summarize(output int mismatches, output int errors);
		if (next_idx < exp_addr.size()) begin
			$display("ERROR: %0d expected stores never happened, first missing is from test %s",
				exp_addr.size() - next_idx, exp_name[next_idx]);
			error_count++;
		end
		mismatches = mismatch_count;
		errors     = error_count;
	endtask

	initial begin
		done           = 1'b0;
		next_idx       = 0;
		mismatch_count = 0;
		error_count    = 0;
		read_expected();
	end

	////////////////////
	// port monitor
	////////////////////

	// values before the edge belong to the mem cycle that just ended
	// the port is only defined once reset has acted on the pipeline
	always @(posedge clk) begin
		if (dmem_we === 1'b1) begin
			check_store();
		end else if (dmem_we !== 1'b0 && rst !== 1'b1) begin
			$display("ERROR: dmem_we is unknown at %0t", $time);
			error_count++;
		end
		// lw and sw never sit in the mem stage together
		if (dmem_we === 1'b1 && dmem_re !== 1'b0) begin
			$display("ERROR: dmem_re is not low during a store at %0t", $time);
			error_count++;
		end
		done <= (exp_addr.size() > 0) && (next_idx == exp_addr.size());
	end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module tb_top;

	// cycles allowed for the whole program after reset
	localparam int RUN_TIMEOUT = 200;
	// idle cycles after the last store, long before the pc wraps to word 0
	localparam int DRAIN_CYCLES = 6;
	localparam int IMEM_WORDS = 1 << `IMEM_ADDR_W;
	localparam int DMEM_WORDS = 1 << `DMEM_ADDR_W;

	logic                    clk;
	logic                    rst;
	logic [`XLEN-1:0]        imem_data;
	logic [`XLEN-1:0]        dmem_rdata;
	logic [`IMEM_ADDR_W-1:0] imem_addr;
	logic [`DMEM_ADDR_W-1:0] dmem_addr;
	logic [`XLEN-1:0]        dmem_wdata;
	logic                    dmem_we;
	logic                    dmem_re;
	logic                    done;

	// program and data images
	logic [`XLEN-1:0] imem [IMEM_WORDS];
	logic [`XLEN-1:0] dmem [DMEM_WORDS];

	int file_errors;
	int timeout_errors;
	int mismatches;
	int checker_errors;
	int cycles;

	// consume the rest of the current line, comments included
	task automatic skip_line(input int fd);
		int c;
		c = $fgetc(fd);
		while (c != 10 && c != -1) begin
			c = $fgetc(fd);
		end
	endtask

	// zero words are no-ops, data words carry their own address
	task automatic fill_memories();
		for (int a = 0; a < IMEM_WORDS; a++) begin
			imem[a] = '0;
		end
		for (int a = 0; a < DMEM_WORDS; a++) begin
			dmem[a] = 32'hbadc0000 + a;
		end
	endtask

	// T lines name a test, I lines are program words, D lines preset data
	task automatic load_golden();
		int               fd;
		int               n_instr;
		int               addr;
		string            tag;
		string            name;
		logic [`XLEN-1:0] word;
		fd = $fopen("bench/golden_program.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open bench/golden_program.txt");
			file_errors++;
			return;
		end
		n_instr = 0;
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "T") begin
				if ($fscanf(fd, "%s", name) == 1) begin
					$display("loading test %s", name);
				end
			end else if (tag == "I") begin
				if ($fscanf(fd, "%h", word) == 1 && n_instr < IMEM_WORDS) begin
					imem[n_instr] = word;
					n_instr++;
				end else begin
					$display("ERROR: bad or surplus instruction line in golden file");
					file_errors++;
				end
			end else if (tag == "D") begin
				if ($fscanf(fd, "%d %h", addr, word) == 2 && addr < DMEM_WORDS) begin
					dmem[addr] = word;
				end else begin
					$display("ERROR: bad data line in golden file");
					file_errors++;
				end
			end
			// S lines belong to the checker
			skip_line(fd);
		end
		$fclose(fd);
		$display("loaded %0d instruction words", n_instr);
	endtask

	////////////////////
	// clock
	////////////////////

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

	////////////////////
	// memory models
	////////////////////

	// store lands on the edge ending the mem cycle
	// read data follows the new addresses 1 ns after the edge
	// data memory only answers while a load asks for it
	always @(posedge clk) begin
		if (dmem_we === 1'b1) begin
			dmem[dmem_addr] = dmem_wdata;
		end
		#1;
		imem_data = imem[imem_addr];
		if (dmem_re === 1'b1) begin
			dmem_rdata = dmem[dmem_addr];
		end else begin
			dmem_rdata = 'x;
		end
	end

	mips_pipeline_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.imem_data  (imem_data),
		.dmem_rdata (dmem_rdata),
		.imem_addr  (imem_addr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re)
	);

	store_checker i_store_checker (
		.clk        (clk),
		.rst        (rst),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.done       (done)
	);

	////////////////////
	// run control
	////////////////////

	initial begin
		rst            = 1'b1;
		imem_data      = '0;
		dmem_rdata     = '0;
		file_errors    = 0;
		timeout_errors = 0;
		fill_memories();
		load_golden();
		// three edges in reset, release just after the third
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		// wait for every expected store
		cycles = 0;
		while (done !== 1'b1 && cycles < RUN_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (done !== 1'b1) begin
			$display("ERROR: timeout after %0d cycles waiting for the expected stores", cycles);
			timeout_errors++;
		end else begin
			// a stray store right after the last one still gets caught
			repeat (DRAIN_CYCLES) @(posedge clk);
		end
		i_store_checker.summarize(mismatches, checker_errors);
		$display("summary: %0d mismatches, %0d other errors", mismatches,
			checker_errors + file_errors + timeout_errors);
		if (mismatches == 0 && checker_errors == 0 && file_errors == 0 &&
			timeout_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- bench/golden_program.txt
# T name | I instruction word (hex) | D word address (dec) and data word (hex)
# S test name, word address (dec), data (hex): expected stores in program order
D 0 00000007
D 1 00000003
D 2 fffffffb
D 3 0f0f00f5
D 4 12345678
D 5 00000080
T reset_quiet
I ac00003c # sw r0, 60(r0)
S reset_quiet 15 00000000
T alu_ops
I 8c010000 # lw r1, 0(r0)
I 8c020004 # lw r2, 4(r0)
I 8c030008 # lw r3, 8(r0)
I 8c04000c # lw r4, 12(r0)
I 00222820 # add r5, r1, r2
I 00223022 # sub r6, r1, r2
I 00643824 # and r7, r3, r4
I 00244025 # or r8, r1, r4
I 0061482a # slt r9, r3, r1
I 0023502a # slt r10, r1, r3
I 00225827 # nor r11, r1, r2
I ac050040 # sw r5, 64(r0)
I ac060044 # sw r6, 68(r0)
I ac070048 # sw r7, 72(r0)
I ac08004c # sw r8, 76(r0)
I ac090050 # sw r9, 80(r0)
I ac0a0054 # sw r10, 84(r0)
I ac0b0058 # sw r11, 88(r0)
S alu_ops 16 0000000a
S alu_ops 17 00000004
S alu_ops 18 0f0f00f1
S alu_ops 19 0f0f00f7
S alu_ops 20 00000001
S alu_ops 21 00000000
S alu_ops 22 fffffff8
T forwarding
I 00226020 # add r12, r1, r2
I 01816820 # add r13, r12, r1
I 01827020 # add r14, r12, r2
I 018c7820 # add r15, r12, r12
I 00218020 # add r16, r1, r1
I 00428020 # add r16, r2, r2
I 02008820 # add r17, r16, r0
I ac0d005c # sw r13, 92(r0)
I ac0e0060 # sw r14, 96(r0)
I ac0f0064 # sw r15, 100(r0)
I ac110068 # sw r17, 104(r0)
S forwarding 23 00000011
S forwarding 24 0000000d
S forwarding 25 00000014
S forwarding 26 00000006
T load_use
I 8c120010 # lw r18, 16(r0)
I 02419820 # add r19, r18, r1
I ac13006c # sw r19, 108(r0)
I 8c140000 # lw r20, 0(r0)
I ac140070 # sw r20, 112(r0)
S load_use 27 1234567f
S load_use 28 00000007
T mem_offsets
I 8c150014 # lw r21, 20(r0)
I aea1fff8 # sw r1, -8(r21)
I aea20008 # sw r2, 8(r21)
I 8eb6ff88 # lw r22, -120(r21)
I aeb6000c # sw r22, 12(r21)
I 8eb7fff8 # lw r23, -8(r21)
I aeb70010 # sw r23, 16(r21)
I 8c180006 # lw r24, 6(r0)
I aeb80016 # sw r24, 22(r21)
S mem_offsets 30 00000007
S mem_offsets 34 00000003
S mem_offsets 35 fffffffb
S mem_offsets 36 00000007
S mem_offsets 37 00000003
T zero_and_illegal
I 00220020 # add r0, r1, r2
I 8c000000 # lw r0, 0(r0)
I ac000098 # sw r0, 152(r0)
I 20010055 # addi r1, r0, 0x55 is not decoded
I a0010000 # sb r1, 0(r0) is not decoded
I ac01009c # sw r1, 156(r0)
S zero_and_illegal 38 00000000
S zero_and_illegal 39 00000007

//--- list.f
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/mips_pipeline_top.sv
bench/store_checker.sv
bench/tb_top.sv

//--- Bender.yml
package:
  name: mips_pipeline

export_include_dirs:
  - include

sources:
  - source/isa_pkg.sv
  - source/pipe_pkg.sv
  - source/register_file.sv
  - source/fetch_stage.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/memory_writeback.sv
  - source/mips_pipeline_top.sv
  - target: test
    files:
      - bench/store_checker.sv
      - bench/tb_top.sv
